//--- ntt_pkg.sv
//==========================================================================
// Shared constants and structs for the Dilithium modular multiplier
//==========================================================================

package ntt_pkg;

    // Dilithium prime q = 2^23 - 2^13 + 1
    parameter logic [23:0] DILITHIUM_Q = 24'd8380417;

    // Coefficient width, every operand is below q
    parameter int COEFF_W = 23;

    // Default datapath width of the modular correction
    parameter int REG_SIZE = 24;

    // Full product of two coefficients
    parameter int PROD_W = 2 * COEFF_W;

    // Split of a value below 2q for the special adder
    parameter int SPLIT_HI_W = 11;
    parameter int SPLIT_LO_W = 13;

    // Operand pair entering the multiplier
    typedef struct packed {
        logic [COEFF_W-1:0] a;
        logic [COEFF_W-1:0] b;
    } mul_operands_t;

    // Reduced value below 2q, upper and lower parts
    typedef struct packed {
        logic [SPLIT_HI_W-1:0] hi;
        logic [SPLIT_LO_W-1:0] lo;
    } red_split_t;

endpackage

//--- abr_adder.sv
//==========================================================================
// Parameterized adder with carry in and carry out
//==========================================================================

`timescale 1ns/100ps

module abr_adder #(
    parameter int RADIX = 24
) (
    input  logic [RADIX-1:0] a_i,
    input  logic [RADIX-1:0] b_i,
    input  logic             cin_i,
    output logic [RADIX-1:0] s_o,
    output logic             cout_o
);

    // One extra bit holds the carry out
    logic [RADIX:0] sum;

    assign sum = {1'b0, a_i} + {1'b0, b_i} + {{RADIX{1'b0}}, cin_i};

    assign s_o    = sum[RADIX-1:0];
    assign cout_o = sum[RADIX];

endmodule

//--- ntt_special_adder.sv
//==========================================================================
// Recombination of the split value, final subtraction of q, ready pulse
//==========================================================================

`timescale 1ns/100ps

module ntt_special_adder #(
    parameter int REG_SIZE = 24
) (
    // Clock, reset and zeroize
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,

    // Data port
    input  logic                add_en_i,
    input  logic [10:0]         opa_i,
    input  logic [12:0]         opb_i,
    input  logic [REG_SIZE-1:0] prime_i,
    output logic [REG_SIZE-1:0] res_o,
    output logic                ready_o
);

    // Recombined value and its register
    logic [REG_SIZE-1:0] r0;
    logic [REG_SIZE-1:0] r0_reg;

    // Value minus prime
    logic [REG_SIZE-1:0] prime_inv;
    logic [REG_SIZE-1:0] r1;
    logic                carry1;

    // Ready timing, shifts right by one each idle cycle
    logic [1:0]          push_result_reg;

    // Upper part above lower part, below 2q
    assign r0 = REG_SIZE'({opa_i, opb_i});

    // Two's complement of the prime via inverted operand and carry in
    assign prime_inv = ~prime_i;

    abr_adder #(
        .RADIX (REG_SIZE)
    ) adder_sub_i (
        .a_i    (r0_reg),
        .b_i    (prime_inv),
        .cin_i  (1'b1),
        .s_o    (r1),
        .cout_o (carry1)
    );

    // Capture of the recombined value
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            r0_reg <= '0;
        end else if (zeroize) begin
            r0_reg <= '0;
        end else if (add_en_i) begin
            r0_reg <= r0;
        end
    end

    // Ready pulse one cycle after capture
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            push_result_reg <= 2'b00;
        end else if (zeroize) begin
            push_result_reg <= 2'b00;
        end else if (add_en_i) begin
            push_result_reg <= 2'b10;
        end else begin
            push_result_reg <= {1'b0, push_result_reg[1]};
        end
    end

    assign ready_o = push_result_reg[0];

    // Carry out set means no borrow, so the value was at least q
    assign res_o = carry1 ? r1 : r0_reg;

endmodule

//--- ntt_mult_stage.sv
//==========================================================================
// Registered 23 x 23 multiplier with valid flag
//==========================================================================

`timescale 1ns/100ps

module ntt_mult_stage (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize_i,
    input  logic                       enable_i,
    input  ntt_pkg::mul_operands_t     operands_i,
    output logic [ntt_pkg::PROD_W-1:0] prod_o,
    output logic                       prod_valid_o
);

    // Full product of the operand pair
    logic [ntt_pkg::PROD_W-1:0] prod;
    logic [ntt_pkg::PROD_W-1:0] prod_reg;
    logic                       prod_valid_reg;

    // Both operands widened before the multiply
    assign prod = ntt_pkg::PROD_W'(operands_i.a) * ntt_pkg::PROD_W'(operands_i.b);

    // Product captured on the enable strobe, held otherwise
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            prod_reg       <= '0;
            prod_valid_reg <= 1'b0;
        end else if (zeroize_i) begin
            prod_reg       <= '0;
            prod_valid_reg <= 1'b0;
        end else begin
            prod_valid_reg <= enable_i;
            if (enable_i) begin
                prod_reg <= prod;
            end
        end
    end

    assign prod_o       = prod_reg;
    assign prod_valid_o = prod_valid_reg;

endmodule

//--- ntt_mult_reduction.sv
//==========================================================================
// Two-stage folding reduction of the product to a value below 2q
//==========================================================================

`timescale 1ns/100ps

module ntt_mult_reduction (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize_i,
    input  logic [ntt_pkg::PROD_W-1:0] prod_i,
    input  logic                       prod_valid_i,
    output ntt_pkg::red_split_t        split_o,
    output logic                       split_valid_o
);

    // Folding uses 2^23 = 2^13 - 1 mod q
    localparam int FOLD_SHIFT = 13;

    // Width after the first fold, h*(2^13-1) + l < 2^37
    localparam int S1_W = 37;
    // Width after the second fold, < 2^27 + 2^23
    localparam int T_W  = 28;
    // Width of the result, below 2^23 + 2^18
    localparam int RES_W = $bits(ntt_pkg::red_split_t);

    localparam int H1_W = ntt_pkg::PROD_W - ntt_pkg::COEFF_W;
    localparam int H2_W = S1_W - ntt_pkg::COEFF_W;
    localparam int H3_W = T_W - ntt_pkg::COEFF_W;

    //======================================================================
    // Stage one, fold bits at and above 23
    //======================================================================

    logic [H1_W-1:0]             prod_hi;
    logic [ntt_pkg::COEFF_W-1:0] prod_lo;
    logic [S1_W-1:0]             fold1;
    logic [S1_W-1:0]             s1_reg;
    logic                        s1_valid_reg;

    assign prod_hi = prod_i[ntt_pkg::PROD_W-1:ntt_pkg::COEFF_W];
    assign prod_lo = prod_i[ntt_pkg::COEFF_W-1:0];

    // h*2^13 - h never goes negative, so no offset is needed
    assign fold1 = (S1_W'(prod_hi) << FOLD_SHIFT) - S1_W'(prod_hi) + S1_W'(prod_lo);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            s1_reg       <= '0;
            s1_valid_reg <= 1'b0;
        end else if (zeroize_i) begin
            s1_reg       <= '0;
            s1_valid_reg <= 1'b0;
        end else begin
            s1_valid_reg <= prod_valid_i;
            if (prod_valid_i) begin
                s1_reg <= fold1;
            end
        end
    end

    //======================================================================
    // Stage two, fold again and then fold the few remaining top bits
    //======================================================================

    logic [H2_W-1:0]             s1_hi;
    logic [ntt_pkg::COEFF_W-1:0] s1_lo;
    logic [T_W-1:0]              fold2;
    logic [H3_W-1:0]             t_hi;
    logic [ntt_pkg::COEFF_W-1:0] t_lo;
    logic [RES_W-1:0]            fold3;
    ntt_pkg::red_split_t         split_d;
    ntt_pkg::red_split_t         split_reg;
    logic                        split_valid_reg;

    assign s1_hi = s1_reg[S1_W-1:ntt_pkg::COEFF_W];
    assign s1_lo = s1_reg[ntt_pkg::COEFF_W-1:0];

    assign fold2 = (T_W'(s1_hi) << FOLD_SHIFT) - T_W'(s1_hi) + T_W'(s1_lo);

    assign t_hi = fold2[T_W-1:ntt_pkg::COEFF_W];
    assign t_lo = fold2[ntt_pkg::COEFF_W-1:0];

    // Top part is at most 17 here, result stays below 2q
    assign fold3 = (RES_W'(t_hi) << FOLD_SHIFT) - RES_W'(t_hi) + RES_W'(t_lo);

    // Split for the special adder
    assign split_d.hi = fold3[RES_W-1:ntt_pkg::SPLIT_LO_W];
    assign split_d.lo = fold3[ntt_pkg::SPLIT_LO_W-1:0];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            split_reg       <= '0;
            split_valid_reg <= 1'b0;
        end else if (zeroize_i) begin
            split_reg       <= '0;
            split_valid_reg <= 1'b0;
        end else begin
            split_valid_reg <= s1_valid_reg;
            if (s1_valid_reg) begin
                split_reg <= split_d;
            end
        end
    end

    assign split_o       = split_reg;
    assign split_valid_o = split_valid_reg;

endmodule

//--- ntt_modmul.sv
//==========================================================================
// Top level of the modular multiplier for q = 8380417, latency 5 cycles
//==========================================================================

`timescale 1ns/100ps

module ntt_modmul #(
    parameter int REG_SIZE = ntt_pkg::REG_SIZE
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  logic                   enable_i,
    input  ntt_pkg::mul_operands_t operands_i,
    output logic [REG_SIZE-1:0]    res_o,
    output logic                   ready_o
);

    // Multiplier to reducer
    logic [ntt_pkg::PROD_W-1:0] prod;
    logic                       prod_valid;

    // Reducer to special adder
    ntt_pkg::red_split_t        split;
    logic                       split_valid;

    // Product registered one edge after enable
    ntt_mult_stage mult_stage_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .enable_i     (enable_i),
        .operands_i   (operands_i),
        .prod_o       (prod),
        .prod_valid_o (prod_valid)
    );

    // Two folding stages, result below 2q
    ntt_mult_reduction mult_reduction_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .prod_i        (prod),
        .prod_valid_i  (prod_valid),
        .split_o       (split),
        .split_valid_o (split_valid)
    );

    // Final correction below q and ready pulse
    ntt_special_adder #(
        .REG_SIZE (REG_SIZE)
    ) special_adder_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize  (zeroize_i),
        .add_en_i (split_valid),
        .opa_i    (split.hi),
        .opb_i    (split.lo),
        .prime_i  (REG_SIZE'(ntt_pkg::DILITHIUM_Q)),
        .res_o    (res_o),
        .ready_o  (ready_o)
    );

endmodule

//--- tb_clk_gen.sv
//==========================================================================
// Testbench clock and synchronous reset source
//==========================================================================

`timescale 1ns/100ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 10.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic reset_n_o
);

    // Free running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Reset low for the first rising edges, released on an edge
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_n_o <= 1'b1;
    end

endmodule

//--- ntt_modmul_tb.sv
//==========================================================================
// Testbench of the modular multiplier, stimulus, reference model, checks
//==========================================================================

`timescale 1ns/100ps

module ntt_modmul_tb;

    localparam int NUM_RANDOM = 300;
    localparam int NUM_CORNER = 8;
    localparam int NUM_GAP    = 40;
    localparam int MAX_GAP    = 6;
    // Cycles after zeroize in which res_o must stay zero
    localparam int ZERO_HOLD  = 8;
    // Cycles to wait for the last results, well above the latency of 5
    localparam int DRAIN_LIMIT = 16;
    localparam int WATCHDOG_CYCLES =
        (NUM_RANDOM + NUM_CORNER * NUM_CORNER) * 2 + NUM_GAP * MAX_GAP + 200;

    logic                                clk;
    logic                                reset_n;
    logic                                zeroize_i;
    logic                                enable_i;
    ntt_pkg::mul_operands_t              operands_i;
    logic [ntt_pkg::REG_SIZE-1:0]        res_o;
    logic                                ready_o;

    // Reference model state
    logic [ntt_pkg::REG_SIZE-1:0]        exp_q[$];
    logic [ntt_pkg::REG_SIZE-1:0]        exp_head;
    int                                  exp_pending;
    int                                  zero_window;
    int                                  error_count;
    int                                  seed;
    logic [ntt_pkg::COEFF_W-1:0]         corner_vals[NUM_CORNER];

    tb_clk_gen #(
        .PERIOD_NS    (10.0),
        .RESET_CYCLES (3)
    ) clk_gen_i (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    ntt_modmul #(
        .REG_SIZE (ntt_pkg::REG_SIZE)
    ) ntt_modmul_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .enable_i   (enable_i),
        .operands_i (operands_i),
        .res_o      (res_o),
        .ready_o    (ready_o)
    );

    //======================================================================
    // Reference model and helpers
    //======================================================================

    // (a * b) mod q on a wide product
    function automatic logic [ntt_pkg::REG_SIZE-1:0] mod_mul_ref(
        input logic [ntt_pkg::COEFF_W-1:0] a,
        input logic [ntt_pkg::COEFF_W-1:0] b
    );
        logic [63:0] prod;
        prod = 64'(a) * 64'(b);
        return ntt_pkg::REG_SIZE'(prod % 64'(ntt_pkg::DILITHIUM_Q));
    endfunction

    // Random coefficient below q
    function automatic logic [ntt_pkg::COEFF_W-1:0] random_operand();
        logic [31:0] r;
        r = $random(seed);
        return ntt_pkg::COEFF_W'(r % 32'(ntt_pkg::DILITHIUM_Q));
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // One strobe followed by one idle cycle
    task automatic issue_item(
        input logic [ntt_pkg::COEFF_W-1:0] a,
        input logic [ntt_pkg::COEFF_W-1:0] b
    );
        @(posedge clk);
        enable_i     <= 1'b1;
        operands_i.a <= a;
        operands_i.b <= b;
        exp_q.push_back(mod_mul_ref(a, b));
        @(posedge clk);
        enable_i <= 1'b0;
    endtask

    // Items in flight are dropped from the model too
    task automatic apply_zeroize();
        @(posedge clk);
        zeroize_i <= 1'b1;
        exp_q.delete();
        @(posedge clk);
        zeroize_i <= 1'b0;
    endtask

    // Bounded wait for the outstanding results
    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            error_count = error_count + 1;
            $display("Error, %0d items never completed", exp_q.size());
            exp_q.delete();
        end
        idle_cycles(4);
    endtask

    // Front of the queue follows each completed item
    always @(posedge clk) begin
        if (ready_o && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
        end
        if (exp_q.size() != 0) begin
            exp_head <= exp_q[0];
        end
        exp_pending <= exp_q.size();
    end

    // Window after zeroize
    always @(posedge clk) begin
        if (zeroize_i) begin
            zero_window <= ZERO_HOLD;
        end else if (zero_window != 0) begin
            zero_window <= zero_window - 1;
        end
    end

    //======================================================================
    // Checks
    //======================================================================

    // Fixed latency of 5 cycles from the sampled enable
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        enable_i |-> ##5 ready_o)
    else begin
        error_count = error_count + 1;
        $display("FAILED time=%0t signal=ready_o expected=1 actual=%b", $time, $sampled(ready_o));
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        ready_o |-> (res_o == exp_head))
    else begin
        error_count = error_count + 1;
        $display("FAILED time=%0t signal=res_o expected=%0d actual=%0d",
                 $time, $sampled(exp_head), $sampled(res_o));
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        ready_o |=> !ready_o)
    else begin
        error_count = error_count + 1;
        $display("FAILED time=%0t signal=ready_o expected=0 actual=1", $time);
    end

    // Ready without an outstanding item, also covers the time after reset
    assert property (@(posedge clk) disable iff (!reset_n)
        ready_o |-> (exp_pending != 0))
    else begin
        error_count = error_count + 1;
        $display("Error at time %0t, ready_o pulsed with no item outstanding", $time);
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        (zero_window != 0) |-> !ready_o)
    else begin
        error_count = error_count + 1;
        $display("FAILED time=%0t signal=ready_o expected=0 actual=1", $time);
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        (zero_window != 0) |-> (res_o == '0))
    else begin
        error_count = error_count + 1;
        $display("FAILED time=%0t signal=res_o expected=0 actual=%0d", $time, $sampled(res_o));
    end

    //======================================================================
    // Stimulus
    //======================================================================

    initial begin
        int gap;
        enable_i    = 1'b0;
        zeroize_i   = 1'b0;
        operands_i  = '0;
        exp_head    = '0;
        exp_pending = 0;
        zero_window = 0;
        error_count = 0;
        seed        = 47;
        // Small values, powers of two and values next to 2^23 - 2^13
        corner_vals[0] = 23'd0;
        corner_vals[1] = 23'd1;
        corner_vals[2] = 23'd2;
        corner_vals[3] = 23'd8192;
        corner_vals[4] = 23'd4194304;
        corner_vals[5] = ntt_pkg::COEFF_W'(ntt_pkg::DILITHIUM_Q - 3);
        corner_vals[6] = ntt_pkg::COEFF_W'(ntt_pkg::DILITHIUM_Q - 2);
        corner_vals[7] = ntt_pkg::COEFF_W'(ntt_pkg::DILITHIUM_Q - 1);

        wait (reset_n == 1'b1);
        idle_cycles(6);

        // Random pairs every two cycles
        for (int i = 0; i < NUM_RANDOM; i++) begin
            issue_item(random_operand(), random_operand());
        end
        drain_results();

        // Every pair of corner values
        for (int i = 0; i < NUM_CORNER; i++) begin
            for (int j = 0; j < NUM_CORNER; j++) begin
                issue_item(corner_vals[i], corner_vals[j]);
            end
        end
        drain_results();

        // Random gaps of 2 to 6 cycles
        for (int i = 0; i < NUM_GAP; i++) begin
            gap = 2 + ($unsigned($random(seed)) % (MAX_GAP - 1));
            issue_item(random_operand(), random_operand());
            idle_cycles(gap - 2);
        end
        drain_results();

        // Zeroize with two items in flight, then one fresh item
        issue_item(random_operand(), random_operand());
        issue_item(random_operand(), random_operand());
        apply_zeroize();
        idle_cycles(ZERO_HOLD + 4);
        issue_item(random_operand(), random_operand());
        drain_results();

        $display("Run finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d errors", WATCHDOG_CYCLES, error_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- src.f
ntt_pkg.sv
abr_adder.sv
ntt_special_adder.sv
ntt_mult_stage.sv
ntt_mult_reduction.sv
ntt_modmul.sv
tb_clk_gen.sv
ntt_modmul_tb.sv

//--- Bender.yml
package:
  name: ntt_modmul

sources:
  - ntt_pkg.sv
  - abr_adder.sv
  - ntt_special_adder.sv
  - ntt_mult_stage.sv
  - ntt_mult_reduction.sv
  - ntt_modmul.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - ntt_modmul_tb.sv
